/* sim.f */
+incdir+sim
logic/ppu_ctrl_pkg.sv
logic/instr_class_decode.sv
logic/datapath_ctrl_gen.sv
logic/mem_ctrl_gen.sv
logic/flow_ctrl_gen.sv
logic/id_ex_ctrl_reg.sv
logic/ppu_control_unit.sv
sim/tb_ppu_control_unit.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_ppu_control_unit
FILELIST   = sim.f
BUILD_DIR  = obj_dir
COMMON     = --timing --timescale 1ns/1ps --top-module $(TOP)
BUILD_FLAGS = --binary -j 0 -Mdir $(BUILD_DIR) $(COMMON)
LINT_FLAGS = --lint-only $(COMMON)
PASS_MSG   = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* sim/ppu_ctrl_ref_model.svh */
`ifndef ppu_ctrl_ref_model_svh
`define ppu_ctrl_ref_model_svh

// legal encoding of id, register and immediate fields random
function automatic logic [instr_w-1:0] encode_instr(input instr_id_t id);
        logic [opcode_w-1:0] opcode;
        logic [funct_w-1:0]  funct;
        logic [4:0]          rs;
        logic [rt_w-1:0]     rt;
        logic [15:0]         imm;
        logic [instr_w-1:0]  instr;
        opcode = op_rtype;
        funct  = '0;
        rs     = 5'($urandom);
        rt     = 5'($urandom);
        imm    = 16'($urandom);  // also covers rd, shamt and jump target
        case (id)
                id_add:   funct = fn_add;
                id_addu:  funct = fn_addu;
                id_sub:   funct = fn_sub;
                id_subu:  funct = fn_subu;
                id_slt:   funct = fn_slt;
                id_sltu:  funct = fn_sltu;
                id_and:   funct = fn_and;
                id_or:    funct = fn_or;
                id_xor:   funct = fn_xor;
                id_nor:   funct = fn_nor;
                id_sll:   funct = fn_sll;
                id_sllv:  funct = fn_sllv;
                id_sra:   funct = fn_sra;
                id_jr:    funct = fn_jr;
                id_jalr:  funct = fn_jalr;
                id_addi:  opcode = op_addi;
                id_addiu: opcode = op_addiu;
                id_slti:  opcode = op_slti;
                id_andi:  opcode = op_andi;
                id_ori:   opcode = op_ori;
                id_xori:  opcode = op_xori;
                id_lui:   opcode = op_lui;
                id_lb:    opcode = op_lb;
                id_lbu:   opcode = op_lbu;
                id_lh:    opcode = op_lh;
                id_lhu:   opcode = op_lhu;
                id_lw:    opcode = op_lw;
                id_sb:    opcode = op_sb;
                id_sh:    opcode = op_sh;
                id_sw:    opcode = op_sw;
                id_beq:   opcode = op_beq;
                id_bne:   opcode = op_bne;
                id_bgtz:  opcode = op_bgtz;
                id_blez:  opcode = op_blez;
                id_bgez:  opcode = op_regimm;
                id_j:     opcode = op_j;
                id_jal:   opcode = op_jal;
                default:  opcode = op_rtype;
        endcase
        if (id == id_bgez) begin
                rt = rt_bgez;
        end
        instr = {opcode, rs, rt, imm};
        if (opcode == op_rtype) begin
                instr[funct_w-1:0] = funct;
        end
        // all zero would be a bubble, so give sll a nonzero rd
        if (instr == '0) begin
                instr[15:11] = 5'd1;
        end
        return instr;
endfunction

// expected id/ex word, field by field
function automatic logic [ctrl_w-1:0] expected_word(input instr_id_t id);
        logic                  imm_alu;
        logic                  is_load;
        logic                  is_store;
        logic                  reg_alu;
        logic [src_op_w-1:0]   src_op;
        logic [alu_op_w-1:0]   alu_op;
        logic [mem_size_w-1:0] size;
        logic                  dest_wr;
        logic                  rf_en;
        logic                  dest_rt;
        logic                  branch;
        logic                  jump;
        imm_alu  = id inside {id_addi, id_addiu, id_slti, id_andi, id_ori, id_xori};
        is_load  = id inside {id_lb, id_lbu, id_lh, id_lhu, id_lw};
        is_store = id inside {id_sb, id_sh, id_sw};
        reg_alu  = id inside {id_add, id_addu, id_sub, id_subu, id_slt, id_sltu, id_and,
                              id_or, id_xor, id_nor, id_sll, id_sllv, id_sra, id_lui};
        dest_wr  = reg_alu || imm_alu || is_load;
        rf_en    = dest_wr || id == id_jal || id == id_jalr;
        dest_rt  = imm_alu || is_load || id == id_lui || id == id_jal;
        branch   = id inside {id_beq, id_bne, id_bgtz, id_blez, id_bgez};
        jump     = id inside {id_j, id_jal, id_jr, id_jalr};
        if (imm_alu || is_load || is_store) begin
                src_op = src_imm;
        end else if (id == id_lui) begin
                src_op = src_lui;
        end else if (id == id_jal) begin
                src_op = src_jal;
        end else begin
                src_op = src_reg;
        end
        case (id)
                id_sub, id_subu:          alu_op = alu_sub;
                id_and, id_andi:          alu_op = alu_and;
                id_or, id_ori:            alu_op = alu_or;
                id_xor, id_xori:          alu_op = alu_xor;
                id_nor:                   alu_op = alu_nor;
                id_slt, id_sltu, id_slti: alu_op = alu_slt;
                id_lui:                   alu_op = alu_lui;
                id_bgtz, id_bgez:         alu_op = alu_cmp;
                id_jal:                   alu_op = alu_link;
                default:                  alu_op = alu_add;
        endcase
        case (id)
                id_lb, id_lbu, id_sb: size = size_byte;
                id_lh, id_lhu, id_sh: size = size_half;
                id_lw, id_sw:         size = size_word;
                default:              size = '0;
        endcase
        // layout from bit 19 down
        return {jump, dest_rt, jump, dest_wr, src_op, alu_op, is_load, rf_en,
                branch, branch || id == id_jal, size, is_store,
                id inside {id_lb, id_lh, id_lw}, is_load || is_store};
endfunction

`endif

/* sim/tb_ppu_control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ppu_control_unit;
        import ppu_ctrl_pkg::*;

        `include "ppu_ctrl_ref_model.svh"

        logic               clk = 1'b0;
        logic               arst_n;
        logic [instr_w-1:0] instruction;
        logic               instr_valid;
        logic [ctrl_w-1:0]  ctrl_word;
        logic               ctrl_valid;

        logic [ctrl_w-1:0]  exp_q[$];      // words still owed by the DUT
        logic [ctrl_w-1:0]  last_word = '0;
        logic [ctrl_w-1:0]  popped;
        logic               pending_valid = 1'b0;  // strobe the DUT sampled last edge
        int                 error_count = 0;
        int                 check_count = 0;
        int                 test_count = 0;

        ppu_control_unit ppu_control_unit_i (
                .clk         (clk),
                .arst_n      (arst_n),
                .instruction (instruction),
                .instr_valid (instr_valid),
                .ctrl_word   (ctrl_word),
                .ctrl_valid  (ctrl_valid)
        );

        initial begin
                forever #4 clk = ~clk;
        end

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                check_count++;
                if (got !== exp) begin
                        $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t",
                                 name, got, exp, $time);
                        error_count++;
                end
        endtask

        task automatic send_instr(input logic valid, input logic [instr_w-1:0] instr,
                                  input logic [ctrl_w-1:0] exp);
                @(posedge clk);
                instruction <= instr;
                instr_valid <= valid;
                if (valid) begin
                        exp_q.push_back(exp);
                end
        endtask

        // stop strobing and wait for every owed word
        task automatic drain_pipe();
                int waited;
                waited = 0;
                @(posedge clk);
                instr_valid <= 1'b0;
                while (exp_q.size() != 0 && waited < 16) begin
                        @(posedge clk);
                        waited++;
                end
                if (exp_q.size() != 0) begin
                        $display("ERROR: timed out, %0d control words never arrived",
                                 exp_q.size());
                        error_count++;
                        exp_q.delete();
                end
        endtask

        task automatic report_test(input string name, input int errs_before);
                test_count++;
                $display("test %-12s done, %0d errors", name, error_count - errs_before);
        endtask

        function automatic instr_id_t random_kept_id();
                return instr_id_t'($urandom_range(int'(id_jalr), int'(id_add)));
        endfunction

        function automatic logic [instr_w-1:0] random_bad_instr();
                logic [instr_w-1:0] instr;
                int                 kind;
                kind  = $urandom_range(3, 0);
                instr = $urandom;
                case (kind)
                        0: instr = '0;
                        1: begin
                                instr[31:26] = op_rtype;
                                while (instr[5:0] inside {fn_add, fn_addu, fn_sub, fn_subu,
                                        fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu,
                                        fn_sll, fn_sra, fn_sllv, fn_jr, fn_jalr}) begin
                                        instr[5:0] = 6'($urandom);
                                end
                        end
                        2: begin
                                instr[31:26] = op_regimm;
                                while (instr[20:16] == rt_bgez) begin
                                        instr[20:16] = 5'($urandom);
                                end
                        end
                        default: begin
                                while (instr[31:26] inside {op_rtype, op_regimm, op_j, op_jal,
                                        op_beq, op_bne, op_blez, op_bgtz, op_addi, op_addiu,
                                        op_slti, op_andi, op_ori, op_xori, op_lui, op_lb, op_lh,
                                        op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw}) begin
                                        instr[31:26] = 6'($urandom);
                                end
                        end
                endcase
                return instr;
        endfunction

        // sampled mid-cycle, away from the driving edge
        always @(negedge clk) begin
                if (arst_n) begin
                        check_value("ctrl_valid", 32'(ctrl_valid), 32'(pending_valid));
                        if (ctrl_valid && exp_q.size() == 0) begin
                                $display("ERROR: ctrl_valid high with no expected word queued");
                                error_count++;
                        end else if (ctrl_valid) begin
                                popped = exp_q.pop_front();
                                check_value("ctrl_word", 32'(ctrl_word), 32'(popped));
                                last_word = popped;
                        end else begin
                                check_value("ctrl_word", 32'(ctrl_word), 32'(last_word));
                        end
                        pending_valid = instr_valid;
                end
        end

        initial begin
                instr_id_t id;
                int        errs;
                void'($urandom(32'h5c81_adfa));
                arst_n      <= 1'b0;
                instr_valid <= 1'b0;
                instruction <= '0;
                repeat (2) @(posedge clk);
                arst_n <= 1'b1;

                errs = error_count;
                repeat (2) @(negedge clk);
                check_value("ctrl_valid", 32'(ctrl_valid), 32'd0);
                check_value("ctrl_word", 32'(ctrl_word), 32'd0);
                report_test("reset", errs);

                errs = error_count;
                for (int k = int'(id_add); k <= int'(id_jalr); k++) begin
                        id = instr_id_t'(k);
                        send_instr(1'b1, encode_instr(id), expected_word(id));
                        drain_pipe();
                end
                report_test("each_instr", errs);

                errs = error_count;
                repeat (500) begin
                        id = random_kept_id();
                        send_instr(1'b1, encode_instr(id), expected_word(id));
                end
                drain_pipe();
                report_test("back_to_back", errs);

                errs = error_count;
                send_instr(1'b1, '0, '0);
                send_instr(1'b1, {op_rtype, 20'($urandom), 6'b000010}, '0);
                send_instr(1'b1, {6'b111111, 26'($urandom)}, '0);
                send_instr(1'b1, {op_regimm, 5'($urandom), 5'd0, 16'($urandom)}, '0);
                repeat (200) send_instr(1'b1, random_bad_instr(), '0);
                drain_pipe();
                report_test("outside_set", errs);

                errs = error_count;
                repeat (400) begin
                        if ($urandom_range(2, 0) == 0) begin
                                send_instr(1'b0, $urandom, '0);  // gap, junk on the bus
                        end else begin
                                id = random_kept_id();
                                send_instr(1'b1, encode_instr(id), expected_word(id));
                        end
                end
                drain_pipe();
                report_test("valid_gaps", errs);

                $display("tests: %0d, checks: %0d, errors: %0d",
                         test_count, check_count, error_count);
                if (error_count == 0) begin
                        $display("Simulation finished: PASS");
                end else begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* logic/ppu_control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_control_unit (
        input  wire                             clk,
        input  wire                             arst_n,
        input  wire [ppu_ctrl_pkg::instr_w-1:0] instruction,
        input  wire                             instr_valid,
        output logic [ppu_ctrl_pkg::ctrl_w-1:0] ctrl_word,
        output logic                            ctrl_valid
);
        import ppu_ctrl_pkg::*;

        instr_id_t             instr_id;  // shared by all three generators
        logic [src_op_w-1:0]   src_op;
        logic [alu_op_w-1:0]   alu_op;
        logic                  rf_en;
        logic                  dest_wr;
        logic                  dest_rt;
        logic                  load;
        logic                  mem_en;
        logic [mem_size_w-1:0] mem_size;
        logic                  mem_rw;
        logic                  mem_se;
        logic                  branch;
        logic                  ta;
        logic                  jump;
        logic                  uncond;

        instr_class_decode instr_class_decode_i (
                .instruction (instruction),
                .instr_id    (instr_id)
        );

        datapath_ctrl_gen datapath_ctrl_gen_i (
                .instr_id (instr_id),
                .src_op   (src_op),
                .alu_op   (alu_op),
                .rf_en    (rf_en),
                .dest_wr  (dest_wr),
                .dest_rt  (dest_rt)
        );

        mem_ctrl_gen mem_ctrl_gen_i (
                .instr_id (instr_id),
                .load     (load),
                .mem_en   (mem_en),
                .mem_size (mem_size),
                .mem_rw   (mem_rw),
                .mem_se   (mem_se)
        );

        flow_ctrl_gen flow_ctrl_gen_i (
                .instr_id (instr_id),
                .branch   (branch),
                .ta       (ta),
                .jump     (jump),
                .uncond   (uncond)
        );

        id_ex_ctrl_reg id_ex_ctrl_reg_i (
                .clk         (clk),
                .arst_n      (arst_n),
                .instr_valid (instr_valid),
                .src_op      (src_op),
                .alu_op      (alu_op),
                .rf_en       (rf_en),
                .dest_wr     (dest_wr),
                .dest_rt     (dest_rt),
                .load        (load),
                .mem_en      (mem_en),
                .mem_size    (mem_size),
                .mem_rw      (mem_rw),
                .mem_se      (mem_se),
                .branch      (branch),
                .ta          (ta),
                .jump        (jump),
                .uncond      (uncond),
                .ctrl_word   (ctrl_word),
                .ctrl_valid  (ctrl_valid)
        );

endmodule

`default_nettype wire

/* logic/id_ex_ctrl_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_ctrl_reg (
        input  wire                                clk,
        input  wire                                arst_n,
        input  wire                                instr_valid,
        input  wire [ppu_ctrl_pkg::src_op_w-1:0]   src_op,
        input  wire [ppu_ctrl_pkg::alu_op_w-1:0]   alu_op,
        input  wire                                rf_en,
        input  wire                                dest_wr,
        input  wire                                dest_rt,
        input  wire                                load,
        input  wire                                mem_en,
        input  wire [ppu_ctrl_pkg::mem_size_w-1:0] mem_size,
        input  wire                                mem_rw,
        input  wire                                mem_se,
        input  wire                                branch,
        input  wire                                ta,
        input  wire                                jump,
        input  wire                                uncond,
        output logic [ppu_ctrl_pkg::ctrl_w-1:0]    ctrl_word,
        output logic                               ctrl_valid
);
        import ppu_ctrl_pkg::*;

        logic [ctrl_w-1:0] next_word;

        always_comb begin
                next_word                                   = '0;
                next_word[bit_uncond]                       = uncond;
                next_word[bit_dest_rt]                      = dest_rt;
                next_word[bit_jump]                         = jump;
                next_word[bit_dest_wr]                      = dest_wr;
                next_word[bit_src_op_lsb +: src_op_w]       = src_op;
                next_word[bit_alu_op_lsb +: alu_op_w]       = alu_op;
                next_word[bit_load]                         = load;
                next_word[bit_rf_en]                        = rf_en;
                next_word[bit_branch]                       = branch;
                next_word[bit_ta]                           = ta;
                next_word[bit_mem_size_lsb +: mem_size_w]   = mem_size;
                next_word[bit_mem_rw]                       = mem_rw;
                next_word[bit_mem_se]                       = mem_se;
                next_word[bit_mem_en]                       = mem_en;
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        ctrl_word  <= '0;
                        ctrl_valid <= 1'b0;
                end else begin
                        ctrl_valid <= instr_valid;
                        if (instr_valid) begin
                                ctrl_word <= next_word;  // holds between strobes
                        end
                end
        end

endmodule

`default_nettype wire

/* logic/flow_ctrl_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module flow_ctrl_gen (
        input  wire ppu_ctrl_pkg::instr_id_t instr_id,
        output logic                         branch,
        output logic                         ta,
        output logic                         jump,
        output logic                         uncond
);
        import ppu_ctrl_pkg::*;

        assign branch = instr_id inside {id_beq, id_bne, id_bgtz, id_blez, id_bgez};
        assign ta     = branch || (instr_id == id_jal);  // pc-relative or jal target
        assign jump   = instr_id inside {id_j, id_jal, id_jr, id_jalr};

        // every jump is taken without a condition
        assign uncond = jump;

endmodule

`default_nettype wire

/* logic/mem_ctrl_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_gen (
        input  wire ppu_ctrl_pkg::instr_id_t        instr_id,
        output logic                                load,
        output logic                                mem_en,
        output logic [ppu_ctrl_pkg::mem_size_w-1:0] mem_size,
        output logic                                mem_rw,
        output logic                                mem_se
);
        import ppu_ctrl_pkg::*;

        assign load   = instr_id inside {id_lb, id_lbu, id_lh, id_lhu, id_lw};
        assign mem_rw = instr_id inside {id_sb, id_sh, id_sw};  // high means write
        assign mem_en = load || mem_rw;
        assign mem_se = instr_id inside {id_lb, id_lh, id_lw};  // signed loads only

        always_comb begin
                case (instr_id)
                        id_lb, id_lbu, id_sb: mem_size = size_byte;
                        id_lh, id_lhu, id_sh: mem_size = size_half;
                        id_lw, id_sw:         mem_size = size_word;
                        default:              mem_size = '0;
                endcase
        end

endmodule

`default_nettype wire

/* logic/datapath_ctrl_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath_ctrl_gen (
        input  wire ppu_ctrl_pkg::instr_id_t     instr_id,
        output logic [ppu_ctrl_pkg::src_op_w-1:0] src_op,
        output logic [ppu_ctrl_pkg::alu_op_w-1:0] alu_op,
        output logic                              rf_en,
        output logic                              dest_wr,
        output logic                              dest_rt
);
        import ppu_ctrl_pkg::*;

        logic imm_alu;   // addi .. xori
        logic load_op;
        logic store_op;
        logic reg_write; // r-type alu, shifts, lui

        assign imm_alu  = instr_id inside {id_addi, id_addiu, id_slti, id_andi, id_ori, id_xori};
        assign load_op  = instr_id inside {id_lb, id_lbu, id_lh, id_lhu, id_lw};
        assign store_op = instr_id inside {id_sb, id_sh, id_sw};
        assign reg_write = instr_id inside {id_add, id_addu, id_sub, id_subu, id_slt, id_sltu,
                                            id_and, id_or, id_xor, id_nor,
                                            id_sll, id_sllv, id_sra, id_lui};

        assign dest_wr = reg_write || imm_alu || load_op;
        assign rf_en   = dest_wr || (instr_id inside {id_jal, id_jalr});  // links write too
        assign dest_rt = imm_alu || load_op || (instr_id inside {id_lui, id_jal});

        always_comb begin
                if (imm_alu || load_op || store_op) begin
                        src_op = src_imm;  // address or immediate operand
                end else if (instr_id == id_lui) begin
                        src_op = src_lui;
                end else if (instr_id == id_jal) begin
                        src_op = src_jal;
                end else begin
                        src_op = src_reg;
                end
        end

        always_comb begin
                case (instr_id)
                        id_sub, id_subu:          alu_op = alu_sub;
                        id_and, id_andi:          alu_op = alu_and;
                        id_or, id_ori:            alu_op = alu_or;
                        id_xor, id_xori:          alu_op = alu_xor;
                        id_nor:                   alu_op = alu_nor;
                        id_slt, id_sltu, id_slti: alu_op = alu_slt;
                        id_lui:                   alu_op = alu_lui;
                        id_bgtz, id_bgez:         alu_op = alu_cmp;
                        id_jal:                   alu_op = alu_link;
                        default:                  alu_op = alu_add;  // adds, shifts, addresses
                endcase
        end

endmodule

`default_nettype wire

/* logic/instr_class_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_class_decode (
        input  wire [ppu_ctrl_pkg::instr_w-1:0] instruction,
        output ppu_ctrl_pkg::instr_id_t         instr_id
);
        import ppu_ctrl_pkg::*;

        logic [opcode_w-1:0] opcode;
        logic [funct_w-1:0]  funct;
        logic [rt_w-1:0]     rt;
        instr_id_t           rtype_id;  // R-type result, picked by funct

        assign opcode = instruction[instr_w-1 -: opcode_w];
        assign funct  = instruction[funct_w-1:0];
        assign rt     = instruction[16 +: rt_w];  // rt field at 20:16

        always_comb begin
                case (funct)
                        fn_add:  rtype_id = id_add;
                        fn_addu: rtype_id = id_addu;
                        fn_sub:  rtype_id = id_sub;
                        fn_subu: rtype_id = id_subu;
                        fn_and:  rtype_id = id_and;
                        fn_or:   rtype_id = id_or;
                        fn_xor:  rtype_id = id_xor;
                        fn_nor:  rtype_id = id_nor;
                        fn_slt:  rtype_id = id_slt;
                        fn_sltu: rtype_id = id_sltu;
                        fn_sll:  rtype_id = id_sll;
                        fn_sllv: rtype_id = id_sllv;
                        fn_sra:  rtype_id = id_sra;
                        fn_jr:   rtype_id = id_jr;
                        fn_jalr: rtype_id = id_jalr;
                        default: rtype_id = id_none;
                endcase
        end

        always_comb begin
                case (opcode)
                        op_rtype:  instr_id = rtype_id;
                        op_regimm: instr_id = (rt == rt_bgez) ? id_bgez : id_none;
                        op_j:      instr_id = id_j;
                        op_jal:    instr_id = id_jal;
                        op_beq:    instr_id = id_beq;
                        op_bne:    instr_id = id_bne;
                        op_blez:   instr_id = id_blez;
                        op_bgtz:   instr_id = id_bgtz;
                        op_addi:   instr_id = id_addi;
                        op_addiu:  instr_id = id_addiu;
                        op_slti:   instr_id = id_slti;
                        op_andi:   instr_id = id_andi;
                        op_ori:    instr_id = id_ori;
                        op_xori:   instr_id = id_xori;
                        op_lui:    instr_id = id_lui;
                        op_lb:     instr_id = id_lb;
                        op_lh:     instr_id = id_lh;
                        op_lw:     instr_id = id_lw;
                        op_lbu:    instr_id = id_lbu;
                        op_lhu:    instr_id = id_lhu;
                        op_sb:     instr_id = id_sb;
                        op_sh:     instr_id = id_sh;
                        op_sw:     instr_id = id_sw;
                        default:   instr_id = id_none;
                endcase
                // the all-zero word is a pipeline bubble, not sll $0
                if (instruction == '0) begin
                        instr_id = id_none;
                end
        end

endmodule

`default_nettype wire

/* logic/ppu_ctrl_pkg.sv */
`default_nettype none

package ppu_ctrl_pkg;

        localparam int instr_w    = 32;
        localparam int opcode_w   = 6;
        localparam int funct_w    = 6;
        localparam int rt_w       = 5;
        localparam int src_op_w   = 3;
        localparam int alu_op_w   = 4;
        localparam int mem_size_w = 2;
        localparam int ctrl_w     = 20;

        // primary opcodes, bits 31:26
        localparam logic [opcode_w-1:0] op_rtype  = 6'b000000;
        localparam logic [opcode_w-1:0] op_regimm = 6'b000001;  // bgez lives here
        localparam logic [opcode_w-1:0] op_j      = 6'b000010;
        localparam logic [opcode_w-1:0] op_jal    = 6'b000011;
        localparam logic [opcode_w-1:0] op_beq    = 6'b000100;
        localparam logic [opcode_w-1:0] op_bne    = 6'b000101;
        localparam logic [opcode_w-1:0] op_blez   = 6'b000110;
        localparam logic [opcode_w-1:0] op_bgtz   = 6'b000111;
        localparam logic [opcode_w-1:0] op_addi   = 6'b001000;
        localparam logic [opcode_w-1:0] op_addiu  = 6'b001001;
        localparam logic [opcode_w-1:0] op_slti   = 6'b001010;
        localparam logic [opcode_w-1:0] op_andi   = 6'b001100;
        localparam logic [opcode_w-1:0] op_ori    = 6'b001101;
        localparam logic [opcode_w-1:0] op_xori   = 6'b001110;
        localparam logic [opcode_w-1:0] op_lui    = 6'b001111;
        localparam logic [opcode_w-1:0] op_lb     = 6'b100000;
        localparam logic [opcode_w-1:0] op_lh     = 6'b100001;
        localparam logic [opcode_w-1:0] op_lw     = 6'b100011;
        localparam logic [opcode_w-1:0] op_lbu    = 6'b100100;
        localparam logic [opcode_w-1:0] op_lhu    = 6'b100101;
        localparam logic [opcode_w-1:0] op_sb     = 6'b101000;
        localparam logic [opcode_w-1:0] op_sh     = 6'b101001;
        localparam logic [opcode_w-1:0] op_sw     = 6'b101011;

        // R-type funct, bits 5:0
        localparam logic [funct_w-1:0] fn_add  = 6'b100000;
        localparam logic [funct_w-1:0] fn_addu = 6'b100001;
        localparam logic [funct_w-1:0] fn_sub  = 6'b100010;
        localparam logic [funct_w-1:0] fn_subu = 6'b100011;
        localparam logic [funct_w-1:0] fn_and  = 6'b100100;
        localparam logic [funct_w-1:0] fn_or   = 6'b100101;
        localparam logic [funct_w-1:0] fn_xor  = 6'b100110;
        localparam logic [funct_w-1:0] fn_nor  = 6'b100111;
        localparam logic [funct_w-1:0] fn_slt  = 6'b101010;
        localparam logic [funct_w-1:0] fn_sltu = 6'b101011;
        localparam logic [funct_w-1:0] fn_sll  = 6'b000000;
        localparam logic [funct_w-1:0] fn_sra  = 6'b000011;
        localparam logic [funct_w-1:0] fn_sllv = 6'b000100;
        localparam logic [funct_w-1:0] fn_jr   = 6'b001000;
        localparam logic [funct_w-1:0] fn_jalr = 6'b001001;

        localparam logic [rt_w-1:0] rt_bgez = 5'd1;

        // source operand select
        localparam logic [src_op_w-1:0] src_reg = 3'b000;
        localparam logic [src_op_w-1:0] src_jal = 3'b011;
        localparam logic [src_op_w-1:0] src_imm = 3'b100;
        localparam logic [src_op_w-1:0] src_lui = 3'b101;

        localparam logic [alu_op_w-1:0] alu_add  = 4'b0000;
        localparam logic [alu_op_w-1:0] alu_sub  = 4'b0001;
        localparam logic [alu_op_w-1:0] alu_and  = 4'b0010;
        localparam logic [alu_op_w-1:0] alu_or   = 4'b0011;
        localparam logic [alu_op_w-1:0] alu_xor  = 4'b0100;
        localparam logic [alu_op_w-1:0] alu_nor  = 4'b0101;
        localparam logic [alu_op_w-1:0] alu_slt  = 4'b1001;
        localparam logic [alu_op_w-1:0] alu_cmp  = 4'b1010;  // compare rs against zero
        localparam logic [alu_op_w-1:0] alu_lui  = 4'b1011;
        localparam logic [alu_op_w-1:0] alu_link = 4'b1100;  // return address

        localparam logic [mem_size_w-1:0] size_byte = 2'b00;
        localparam logic [mem_size_w-1:0] size_half = 2'b01;
        localparam logic [mem_size_w-1:0] size_word = 2'b10;

        typedef enum logic [5:0] {
                id_none,
                id_add, id_addu, id_sub, id_subu, id_slt, id_sltu,
                id_and, id_or, id_xor, id_nor,
                id_addi, id_addiu, id_slti, id_andi, id_ori, id_xori,
                id_lui,
                id_sll, id_sllv, id_sra,
                id_lb, id_lbu, id_lh, id_lhu, id_lw,
                id_sb, id_sh, id_sw,
                id_beq, id_bne, id_bgtz, id_blez, id_bgez,
                id_j, id_jal, id_jr, id_jalr
        } instr_id_t;

        // id/ex control word bit positions
        localparam int bit_uncond       = 19;
        localparam int bit_dest_rt      = 18;
        localparam int bit_jump         = 17;
        localparam int bit_dest_wr      = 16;
        localparam int bit_src_op_lsb   = 13;
        localparam int bit_alu_op_lsb   = 9;
        localparam int bit_load         = 8;
        localparam int bit_rf_en        = 7;
        localparam int bit_branch       = 6;
        localparam int bit_ta           = 5;
        localparam int bit_mem_size_lsb = 3;
        localparam int bit_mem_rw       = 2;
        localparam int bit_mem_se       = 1;
        localparam int bit_mem_en       = 0;

endpackage

`default_nettype wire
